/* tb.f */
+incdir+tb
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_result.sv
logic/ex_stage.sv
tb/ex_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/ex_decode.sv
  - logic/ex_alu.sv
  - logic/ex_result.sv
  - logic/ex_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ex_tb.sv

/* tb/ex_ref.svh */
`ifndef EX_REF_SVH
`define EX_REF_SVH

// one expected result per instruction sent
typedef struct packed {
	logic [WORD_W-1:0] data;
	logic [REG_W-1:0] wreg;
	logic exc;
	logic [EXC_W-1:0] code;
} exp_t;

// the sum fits a signed word only if its low word sign-extends back to it
function automatic logic out_of_range(input longint v);
	return v != longint'($signed(v[31:0]));
endfunction

// run of equal bits from the top
function automatic int count_lead(input logic [WORD_W-1:0] w, input logic b);
	int n;
	n = 0;
	while (n < WORD_W && w[WORD_W-1-n] == b) begin
		n++;
	end
	return n;
endfunction

function automatic exp_t expect_result(
	input logic [WORD_W-1:0] iw,
	input logic [WORD_W-1:0] pc_v,
	input logic [WORD_W-1:0] rs_v,
	input logic [WORD_W-1:0] rt_v,
	input logic xin_v,
	input logic [EXC_W-1:0] xin_c
);
	exp_t e;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] sa;
	logic [WORD_W-1:0] se;
	logic [WORD_W-1:0] ze;
	longint wide;
	logic ov;
	logic sys;
	logic brk;
	e = '0;
	ov = 1'b0;
	sys = 1'b0;
	brk = 1'b0;
	wide = 0;
	op = iw[31:26];
	fn = iw[5:0];
	sa = iw[10:6];
	se = {{16{iw[15]}}, iw[15:0]};
	ze = {16'h0000, iw[15:0]};
	if (op == OP_SPECIAL) begin
		e.wreg = iw[15:11];
		case (fn)
			FN_AND: e.data = rs_v & rt_v;
			FN_OR: e.data = rs_v | rt_v;
			FN_XOR: e.data = rs_v ^ rt_v;
			FN_NOR: e.data = ~(rs_v | rt_v);
			FN_SLL: e.data = rt_v << sa;
			FN_SRL: e.data = rt_v >> sa;
			FN_SRA: e.data = $signed(rt_v) >>> sa;
			FN_SLLV: e.data = rt_v << rs_v[4:0];
			FN_SRLV: e.data = rt_v >> rs_v[4:0];
			FN_SRAV: e.data = $signed(rt_v) >>> rs_v[4:0];
			FN_ADD, FN_ADDU: begin
				wide = longint'($signed(rs_v)) + longint'($signed(rt_v));
				e.data = wide[31:0];
				ov = (fn == FN_ADD) && out_of_range(wide);
			end
			FN_SUB, FN_SUBU: begin
				wide = longint'($signed(rs_v)) - longint'($signed(rt_v));
				e.data = wide[31:0];
				ov = (fn == FN_SUB) && out_of_range(wide);
			end
			FN_SLT: e.data = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
			FN_SLTU: e.data = (rs_v < rt_v) ? 32'd1 : 32'd0;
			FN_SYSCALL: sys = 1'b1;
			FN_BREAK: brk = 1'b1;
			default: e.wreg = '0;
		endcase
		if (sys || brk) begin
			e.wreg = '0;
		end
	end else if (op == OP_SPECIAL2) begin
		e.wreg = iw[15:11];
		if (fn == FN_CLZ) begin
			e.data = count_lead(rs_v, 1'b0);
		end else if (fn == FN_CLO) begin
			e.data = count_lead(rs_v, 1'b1);
		end else begin
			e.wreg = '0;
		end
	end else begin
		e.wreg = iw[20:16];
		case (op)
			OP_JAL: begin
				e.data = pc_v + 32'd8;
				e.wreg = LINK_REG;
			end
			OP_ADDI, OP_ADDIU: begin
				wide = longint'($signed(rs_v)) + longint'($signed(se));
				e.data = wide[31:0];
				ov = (op == OP_ADDI) && out_of_range(wide);
			end
			OP_SLTI: e.data = ($signed(rs_v) < $signed(se)) ? 32'd1 : 32'd0;
			OP_SLTIU: e.data = (rs_v < se) ? 32'd1 : 32'd0;
			OP_ANDI: e.data = rs_v & ze;
			OP_ORI: e.data = rs_v | ze;
			OP_XORI: e.data = rs_v ^ ze;
			OP_LUI: e.data = {iw[15:0], 16'h0000};
			default: e.wreg = '0;
		endcase
	end
	// earlier stage first, then overflow, syscall, break
	if (xin_v) begin
		e.exc = 1'b1;
		e.code = xin_c;
	end else if (ov) begin
		e.exc = 1'b1;
		e.code = EXC_OVERFLOW;
	end else if (sys) begin
		e.exc = 1'b1;
		e.code = EXC_SYSCALL;
	end else if (brk) begin
		e.exc = 1'b1;
		e.code = EXC_BREAK;
	end
	if (e.exc) begin
		e.wreg = '0;
	end
	return e;
endfunction

`endif

/* tb/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;

	import ex_pkg::*;

	`include "ex_ref.svh"

	localparam int SEED = 73188;
	localparam int N_RANDOM = 200;
	localparam int CLK_PERIOD = 8;
	localparam int MAX_GAP = 3;
	// upper bound on the directed instructions of the first five tests
	localparam int N_DIRECTED = 60;
	localparam int N_TESTS = 6;
	localparam int TIMEOUT =
		(N_DIRECTED + N_RANDOM * (MAX_GAP + 1) + N_TESTS * 8 + 20) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic inst_valid;
	instr_t inst;
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] rs_value;
	logic [WORD_W-1:0] rt_value;
	logic exc_in_valid;
	logic [EXC_W-1:0] exc_in_code;
	logic res_valid;
	logic [WORD_W-1:0] write_data;
	logic [REG_W-1:0] write_reg;
	logic exc_valid;
	logic [EXC_W-1:0] exc_code;

	integer seed;
	exp_t exp_q[$];
	exp_t cur;
	logic [1:0] vhist;
	int errors;
	int checks;
	int errors_at_start;
	int checks_at_start;
	logic [WORD_W-1:0] pc_next;

	ex_stage UUT (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc(pc),
		.rs_value(rs_value),
		.rt_value(rt_value),
		.exc_in_valid(exc_in_valid),
		.exc_in_code(exc_in_code),
		.res_valid(res_valid),
		.write_data(write_data),
		.write_reg(write_reg),
		.exc_valid(exc_valid),
		.exc_code(exc_code)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [WORD_W-1:0] r_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {op, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [WORD_W-1:0] i_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [REG_W-1:0] rand_reg();
		return REG_W'($random(seed));
	endfunction

	function automatic logic [5:0] pick_funct(input int k);
		case (k)
			0: return FN_SLL;
			1: return FN_SRL;
			2: return FN_SRA;
			3: return FN_SLLV;
			4: return FN_SRLV;
			5: return FN_SRAV;
			6: return FN_SYSCALL;
			7: return FN_BREAK;
			8: return FN_ADD;
			9: return FN_ADDU;
			10: return FN_SUB;
			11: return FN_SUBU;
			12: return FN_AND;
			13: return FN_OR;
			14: return FN_XOR;
			15: return FN_NOR;
			16: return FN_SLT;
			default: return FN_SLTU;
		endcase
	endfunction

	function automatic logic [5:0] pick_iop(input int k);
		case (k)
			0: return OP_ADDI;
			1: return OP_ADDIU;
			2: return OP_SLTI;
			3: return OP_SLTIU;
			4: return OP_ANDI;
			5: return OP_ORI;
			6: return OP_XORI;
			default: return OP_LUI;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [WORD_W-1:0] exp_v,
		input logic [WORD_W-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("Fail t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_W-1:0] exp_v,
		input logic [REG_W-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("Fail t=%0t %s expected %0d got %0d", $time, name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic check_exc(input logic exp_v, input logic [EXC_W-1:0] exp_c,
		input logic act_v, input logic [EXC_W-1:0] act_c);
		if (act_v !== exp_v) begin
			$display("Fail t=%0t exc_valid expected %b got %b", $time, exp_v, act_v);
			errors++;
		end else if (exp_v && act_c !== exp_c) begin
			$display("Fail t=%0t exc_code expected %0d got %0d", $time, exp_c, act_c);
			errors++;
		end
	endtask

	// outputs are read at the falling edge, half a cycle after they change
	always @(negedge clk) begin
		if (rst !== 1'b0) begin
			vhist = 2'b00;
		end else begin
			if (res_valid !== vhist[1]) begin
				$display("Fail t=%0t res_valid expected %b got %b", $time, vhist[1], res_valid);
				errors++;
			end
			if (res_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("result at t=%0t with no instruction outstanding", $time);
					errors++;
				end else begin
					cur = exp_q.pop_front();
					check_reg("write_reg", cur.wreg, write_reg);
					check_exc(cur.exc, cur.code, exc_valid, exc_code);
					check_word("write_data", cur.data, write_data);
					checks++;
				end
			end
			vhist = {vhist[0], inst_valid};
		end
	end

	task automatic send_full(input logic [WORD_W-1:0] iw, input logic [WORD_W-1:0] pc_v,
		input logic [WORD_W-1:0] rs_v, input logic [WORD_W-1:0] rt_v,
		input logic xin_v, input logic [EXC_W-1:0] xin_c);
		@(posedge clk);
		inst_valid <= 1'b1;
		inst <= iw;
		pc <= pc_v;
		rs_value <= rs_v;
		rt_value <= rt_v;
		exc_in_valid <= xin_v;
		exc_in_code <= xin_c;
		exp_q.push_back(expect_result(iw, pc_v, rs_v, rt_v, xin_v, xin_c));
	endtask

	task automatic send(input logic [WORD_W-1:0] iw, input logic [WORD_W-1:0] rs_v,
		input logic [WORD_W-1:0] rt_v);
		send_full(iw, pc_next, rs_v, rt_v, 1'b0, '0);
		pc_next = pc_next + 32'd4;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			inst_valid <= 1'b0;
		end
	endtask

	task automatic start_test();
		errors_at_start = errors;
		checks_at_start = checks;
	endtask

	task automatic finish_test(input string name);
		idle(1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		$display("%-16s %0d results checked, %0d errors", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	task automatic itype_ops();
		start_test();
		send(i_word(OP_ORI, 5'd1, 5'd2, 16'h8001), 32'h1234_0000, 32'h0);
		send(i_word(OP_ANDI, 5'd3, 5'd4, 16'h8F0F), 32'hFFFF_FFFF, 32'h0);
		send(i_word(OP_XORI, 5'd5, 5'd6, 16'hFFFF), 32'h0F0F_F0F0, 32'h0);
		send(i_word(OP_ADDIU, 5'd7, 5'd8, 16'hFFFE), 32'd10, 32'h0);
		send(i_word(OP_SLTI, 5'd9, 5'd10, 16'hFFFC), 32'hFFFF_FFFB, 32'h0);
		send(i_word(OP_SLTIU, 5'd11, 5'd12, 16'hFFFF), 32'd5, 32'h0);
		send(i_word(OP_SLTIU, 5'd13, 5'd14, 16'h0001), 32'hFFFF_FFFF, 32'h0);
		send(i_word(OP_LUI, 5'd0, 5'd15, 16'hBEEF), 32'h1111_1111, 32'h0);
		send(i_word(OP_ADDI, 5'd16, 5'd17, 16'hFF9C), 32'd100, 32'h0);
		finish_test("i-type");
	endtask

	task automatic rtype_ops();
		start_test();
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FN_AND), 32'hF0F0_1234, 32'h0FF0_FF00);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd4, 5'd0, FN_OR), 32'hF0F0_1234, 32'h0FF0_FF00);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd5, 5'd0, FN_XOR), 32'hF0F0_1234, 32'h0FF0_FF00);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd6, 5'd0, FN_NOR), 32'hF0F0_1234, 32'h0FF0_FF00);
		send(r_word(OP_SPECIAL, 5'd0, 5'd2, 5'd7, 5'd4, FN_SLL), 32'h0, 32'h8765_4321);
		send(r_word(OP_SPECIAL, 5'd0, 5'd2, 5'd8, 5'd31, FN_SRL), 32'h0, 32'h8000_0001);
		send(r_word(OP_SPECIAL, 5'd0, 5'd2, 5'd9, 5'd8, FN_SRA), 32'h0, 32'h8000_0F00);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd10, 5'd0, FN_SLLV), 32'h0000_0023, 32'h0000_00FF);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd11, 5'd0, FN_SRLV), 32'hFFFF_FFE1, 32'hF000_0000);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd12, 5'd0, FN_SRAV), 32'h0000_0005, 32'h8000_0000);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd13, 5'd0, FN_SLT), 32'hFFFF_FFFF, 32'h1);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd14, 5'd0, FN_SLTU), 32'hFFFF_FFFF, 32'h1);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd15, 5'd0, FN_SLT), 32'h1, 32'hFFFF_FFFF);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd16, 5'd0, FN_SLTU), 32'h1, 32'hFFFF_FFFF);
		finish_test("r-type");
	endtask

	task automatic count_and_link();
		logic [WORD_W-1:0] w;
		start_test();
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd2, 5'd0, FN_CLZ), 32'h0, 32'h0);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd3, 5'd0, FN_CLZ), 32'hFFFF_FFFF, 32'h0);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd4, 5'd0, FN_CLZ), 32'h0001_0000, 32'h0);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd5, 5'd0, FN_CLO), 32'hFFFF_FFFF, 32'h0);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd6, 5'd0, FN_CLO), 32'h0, 32'h0);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd7, 5'd0, FN_CLO), 32'hFFF0_0000, 32'h0);
		w = $random(seed);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd8, 5'd0, FN_CLZ), w >> 5, 32'h0);
		w = $random(seed);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd0, 5'd9, 5'd0, FN_CLO), w | 32'hE000_0000, 32'h0);
		send_full({OP_JAL, 26'h010_0040}, 32'h0040_0100, 32'h0, 32'h0, 1'b0, '0);
		w = $random(seed);
		send_full({OP_JAL, 26'h3FF_FFFF}, w & 32'hFFFF_FFFC, 32'h0, 32'h0, 1'b0, '0);
		finish_test("clz/clo/jal");
	endtask

	task automatic overflow_cases();
		start_test();
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), 32'h7FFF_FFFF, 32'h1);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h7FFF_FFFF, 32'h1);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd4, 5'd0, FN_SUB), 32'h8000_0000, 32'h1);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd4, 5'd0, FN_SUBU), 32'h8000_0000, 32'h1);
		send(i_word(OP_ADDI, 5'd1, 5'd5, 16'h0010), 32'h7FFF_FFF0, 32'h0);
		send(i_word(OP_ADDIU, 5'd1, 5'd5, 16'h0010), 32'h7FFF_FFF0, 32'h0);
		send(i_word(OP_ADDI, 5'd1, 5'd6, 16'hFFFF), 32'h8000_0000, 32'h0);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd7, 5'd0, FN_ADD), 32'h8000_0000, 32'h8000_0000);
		finish_test("overflow");
	endtask

	task automatic exception_cases();
		start_test();
		send(r_word(OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd3, FN_SYSCALL), 32'h0, 32'h0);
		send(r_word(OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd7, FN_BREAK), 32'h0, 32'h0);
		// incoming exception beats the overflow
		send_full(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), pc_next,
			32'h7FFF_FFFF, 32'h1, 1'b1, 6'd4);
		send_full(i_word(OP_ORI, 5'd1, 5'd2, 16'h00FF), pc_next, 32'h0, 32'h0, 1'b1, 6'd10);
		send(i_word(6'b110001, 5'd1, 5'd2, 16'h1234), 32'h5555_5555, 32'hAAAA_AAAA);
		send(r_word(OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b011000), 32'h3, 32'h4);
		send(r_word(OP_SPECIAL2, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000010), 32'h3, 32'h4);
		finish_test("exceptions");
	endtask

	task automatic random_one();
		logic [WORD_W-1:0] iw;
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [WORD_W-1:0] p;
		logic xv;
		logic [EXC_W-1:0] xc;
		int kind;
		kind = $unsigned($random(seed)) % 8;
		case (kind)
			0, 1, 2: begin
				iw = r_word(OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(), rand_reg(),
					pick_funct($unsigned($random(seed)) % 18));
			end
			3, 4: begin
				iw = i_word(pick_iop($unsigned($random(seed)) % 8), rand_reg(), rand_reg(),
					16'($random(seed)));
			end
			5: begin
				iw = r_word(OP_SPECIAL2, rand_reg(), 5'd0, rand_reg(), 5'd0,
					($random(seed) & 1) ? FN_CLO : FN_CLZ);
			end
			6: iw = {OP_JAL, 26'($random(seed))};
			default: iw = $random(seed);
		endcase
		a = $random(seed);
		b = $random(seed);
		p = $random(seed) & 32'hFFFF_FFFC;
		// roughly one in eight carries an earlier exception
		xv = ($unsigned($random(seed)) % 8) == 0;
		xc = EXC_W'($random(seed));
		send_full(iw, p, a, b, xv, xc);
	endtask

	task automatic random_traffic();
		int gap;
		start_test();
		for (int n = 0; n < N_RANDOM; n++) begin
			random_one();
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			idle(gap);
		end
		finish_test("random");
	endtask

	initial begin
		#(TIMEOUT);
		$display("watchdog expired after %0d ns, %0d results outstanding", TIMEOUT,
			exp_q.size());
		$display("Test FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		rs_value = '0;
		rt_value = '0;
		exc_in_valid = 1'b0;
		exc_in_code = '0;
		seed = SEED;
		errors = 0;
		checks = 0;
		pc_next = 32'h0040_0000;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		itype_ops();
		rtype_ops();
		count_and_link();
		overflow_cases();
		exception_cases();
		random_traffic();
		$display("%0d results checked, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
	input  logic clk,
	input  logic rst,
	input  logic inst_valid,
	input  ex_pkg::instr_t inst,
	input  logic [ex_pkg::WORD_W-1:0] pc,
	input  logic [ex_pkg::WORD_W-1:0] rs_value,
	input  logic [ex_pkg::WORD_W-1:0] rt_value,
	input  logic exc_in_valid,
	input  logic [ex_pkg::EXC_W-1:0] exc_in_code,
	output logic res_valid,
	output logic [ex_pkg::WORD_W-1:0] write_data,
	output logic [ex_pkg::REG_W-1:0] write_reg,
	output logic exc_valid,
	output logic [ex_pkg::EXC_W-1:0] exc_code
);

	import ex_pkg::*;

	logic d_valid;
	logic [ALU_OP_W-1:0] d_alu_op;
	logic d_ov_check;
	logic d_syscall;
	logic d_break;
	logic [WORD_W-1:0] d_a;
	logic [WORD_W-1:0] d_b;
	logic [SHAMT_W-1:0] d_shamt;
	logic [REG_W-1:0] d_dest;
	logic d_exc_in_valid;
	logic [EXC_W-1:0] d_exc_in_code;
	logic [WORD_W-1:0] alu_result;
	logic alu_overflow;

	ex_decode u_decode (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc(pc),
		.rs_value(rs_value),
		.rt_value(rt_value),
		.exc_in_valid(exc_in_valid),
		.exc_in_code(exc_in_code),
		.d_valid(d_valid),
		.d_alu_op(d_alu_op),
		.d_ov_check(d_ov_check),
		.d_syscall(d_syscall),
		.d_break(d_break),
		.d_a(d_a),
		.d_b(d_b),
		.d_shamt(d_shamt),
		.d_dest(d_dest),
		.d_exc_in_valid(d_exc_in_valid),
		.d_exc_in_code(d_exc_in_code)
	);

	// combinational, sits between the two register stages
	ex_alu u_alu (
		.d_alu_op(d_alu_op),
		.d_ov_check(d_ov_check),
		.d_a(d_a),
		.d_b(d_b),
		.d_shamt(d_shamt),
		.alu_result(alu_result),
		.alu_overflow(alu_overflow)
	);

	ex_result u_result (
		.clk(clk),
		.rst(rst),
		.d_valid(d_valid),
		.d_dest(d_dest),
		.d_syscall(d_syscall),
		.d_break(d_break),
		.d_exc_in_valid(d_exc_in_valid),
		.d_exc_in_code(d_exc_in_code),
		.alu_result(alu_result),
		.alu_overflow(alu_overflow),
		.res_valid(res_valid),
		.write_data(write_data),
		.write_reg(write_reg),
		.exc_valid(exc_valid),
		.exc_code(exc_code)
	);

endmodule

/* logic/ex_result.sv */
`timescale 1ns/1ps

module ex_result (
	input  logic clk,
	input  logic rst,
	input  logic d_valid,
	input  logic [ex_pkg::REG_W-1:0] d_dest,
	input  logic d_syscall,
	input  logic d_break,
	input  logic d_exc_in_valid,
	input  logic [ex_pkg::EXC_W-1:0] d_exc_in_code,
	input  logic [ex_pkg::WORD_W-1:0] alu_result,
	input  logic alu_overflow,
	output logic res_valid,
	output logic [ex_pkg::WORD_W-1:0] write_data,
	output logic [ex_pkg::REG_W-1:0] write_reg,
	output logic exc_valid,
	output logic [ex_pkg::EXC_W-1:0] exc_code
);

	import ex_pkg::*;

	logic exc_hit;
	logic [EXC_W-1:0] exc_sel;

	// earlier stage first, then overflow, syscall, break
	always_comb begin
		exc_hit = 1'b1;
		if (d_exc_in_valid) begin
			exc_sel = d_exc_in_code;
		end else if (alu_overflow) begin
			exc_sel = EXC_OVERFLOW;
		end else if (d_syscall) begin
			exc_sel = EXC_SYSCALL;
		end else if (d_break) begin
			exc_sel = EXC_BREAK;
		end else begin
			exc_hit = 1'b0;
			exc_sel = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			exc_valid <= 1'b0;
		end else begin
			res_valid <= d_valid;
			exc_valid <= d_valid && exc_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid) begin
			write_data <= alu_result;
			// no register write once an exception is taken
			write_reg <= exc_hit ? '0 : d_dest;
			exc_code <= exc_sel;
		end
	end

	a_exc_no_write: assert property (@(posedge clk) disable iff (rst)
		exc_valid |-> write_reg == '0);

	a_quiet_after_rst: assert property (@(posedge clk) rst |=> !res_valid);

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
	input  logic [ex_pkg::ALU_OP_W-1:0] d_alu_op,
	input  logic d_ov_check,
	input  logic [ex_pkg::WORD_W-1:0] d_a,
	input  logic [ex_pkg::WORD_W-1:0] d_b,
	input  logic [ex_pkg::SHAMT_W-1:0] d_shamt,
	output logic [ex_pkg::WORD_W-1:0] alu_result,
	output logic alu_overflow
);

	import ex_pkg::*;

	logic [WORD_W-1:0] sum;
	logic [WORD_W-1:0] diff;
	logic add_ov;
	logic sub_ov;
	logic slt_bit;
	logic sltu_bit;

	// leading zeros, first set bit from the top stops the count
	function automatic logic [WORD_W-1:0] lead_zeros(input logic [WORD_W-1:0] w);
		logic [WORD_W-1:0] n;
		logic done;
		n = '0;
		done = 1'b0;
		for (int i = WORD_W - 1; i >= 0; i--) begin
			if (!done && !w[i]) begin
				n = n + 1'b1;
			end else begin
				done = 1'b1;
			end
		end
		return n;
	endfunction

	assign sum = d_a + d_b;
	assign diff = d_a - d_b;

	// signed overflow: operand signs vs result sign
	assign add_ov = (d_a[WORD_W-1] == d_b[WORD_W-1]) && (sum[WORD_W-1] != d_a[WORD_W-1]);
	assign sub_ov = (d_a[WORD_W-1] != d_b[WORD_W-1]) && (diff[WORD_W-1] != d_a[WORD_W-1]);

	assign alu_overflow = d_ov_check &&
		((d_alu_op == ALU_ADD && add_ov) || (d_alu_op == ALU_SUB && sub_ov));

	assign slt_bit = $signed(d_a) < $signed(d_b);
	assign sltu_bit = d_a < d_b;

	always_comb begin
		case (d_alu_op)
			ALU_AND: begin
				alu_result = d_a & d_b;
			end
			ALU_OR: begin
				alu_result = d_a | d_b;
			end
			ALU_XOR: begin
				alu_result = d_a ^ d_b;
			end
			ALU_NOR: begin
				alu_result = ~(d_a | d_b);
			end
			ALU_ADD: begin
				alu_result = sum;
			end
			ALU_SUB: begin
				alu_result = diff;
			end
			ALU_SLT: begin
				alu_result = {{(WORD_W-1){1'b0}}, slt_bit};
			end
			ALU_SLTU: begin
				alu_result = {{(WORD_W-1){1'b0}}, sltu_bit};
			end
			// shifts work on rt, amount already picked in decode
			ALU_SLL: begin
				alu_result = d_b << d_shamt;
			end
			ALU_SRL: begin
				alu_result = d_b >> d_shamt;
			end
			ALU_SRA: begin
				alu_result = $signed(d_b) >>> d_shamt;
			end
			ALU_LUI: begin
				alu_result = {d_b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
			end
			ALU_CLZ: begin
				alu_result = lead_zeros(d_a);
			end
			ALU_CLO: begin
				alu_result = lead_zeros(~d_a);
			end
			// return address skips the delay slot
			ALU_LINK: begin
				alu_result = d_a + WORD_W'(8);
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

/* logic/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
	input  logic clk,
	input  logic rst,
	input  logic inst_valid,
	input  ex_pkg::instr_t inst,
	input  logic [ex_pkg::WORD_W-1:0] pc,
	input  logic [ex_pkg::WORD_W-1:0] rs_value,
	input  logic [ex_pkg::WORD_W-1:0] rt_value,
	input  logic exc_in_valid,
	input  logic [ex_pkg::EXC_W-1:0] exc_in_code,
	output logic d_valid,
	output logic [ex_pkg::ALU_OP_W-1:0] d_alu_op,
	output logic d_ov_check,
	output logic d_syscall,
	output logic d_break,
	output logic [ex_pkg::WORD_W-1:0] d_a,
	output logic [ex_pkg::WORD_W-1:0] d_b,
	output logic [ex_pkg::SHAMT_W-1:0] d_shamt,
	output logic [ex_pkg::REG_W-1:0] d_dest,
	output logic d_exc_in_valid,
	output logic [ex_pkg::EXC_W-1:0] d_exc_in_code
);

	import ex_pkg::*;

	logic [WORD_W-1:0] imm_sx;
	logic [WORD_W-1:0] imm_zx;
	logic [ALU_OP_W-1:0] alu_op;
	logic ov_check;
	logic is_syscall;
	logic is_break;
	logic [WORD_W-1:0] op_a;
	logic [WORD_W-1:0] op_b;
	logic [SHAMT_W-1:0] shamt;
	logic [REG_W-1:0] dest;

	assign imm_sx = {{(WORD_W-IMM_W){inst.i.imm16[IMM_W-1]}}, inst.i.imm16};
	assign imm_zx = {{(WORD_W-IMM_W){1'b0}}, inst.i.imm16};

	always_comb begin
		alu_op = ALU_ZERO;
		ov_check = 1'b0;
		is_syscall = 1'b0;
		is_break = 1'b0;
		op_a = rs_value;
		op_b = imm_sx;
		shamt = inst.r.shamt;
		dest = inst.i.rt;
		case (inst.r.opcode)
			OP_SPECIAL: begin
				op_b = rt_value;
				dest = inst.r.rd;
				case (inst.r.funct)
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_NOR: alu_op = ALU_NOR;
					FN_SLL: alu_op = ALU_SLL;
					FN_SRL: alu_op = ALU_SRL;
					FN_SRA: alu_op = ALU_SRA;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					// variable shifts take the amount from rs
					FN_SLLV, FN_SRLV, FN_SRAV: begin
						alu_op = (inst.r.funct == FN_SLLV) ? ALU_SLL :
							(inst.r.funct == FN_SRLV) ? ALU_SRL : ALU_SRA;
						shamt = rs_value[SHAMT_W-1:0];
					end
					FN_ADD, FN_SUB: begin
						alu_op = (inst.r.funct == FN_ADD) ? ALU_ADD : ALU_SUB;
						ov_check = 1'b1;
					end
					FN_SYSCALL: begin
						is_syscall = 1'b1;
						dest = '0;
					end
					FN_BREAK: begin
						is_break = 1'b1;
						dest = '0;
					end
					default: dest = '0;
				endcase
			end
			OP_SPECIAL2: begin
				dest = inst.r.rd;
				case (inst.r.funct)
					FN_CLZ: alu_op = ALU_CLZ;
					FN_CLO: alu_op = ALU_CLO;
					default: dest = '0;
				endcase
			end
			OP_JAL: begin
				alu_op = ALU_LINK;
				op_a = pc;
				dest = LINK_REG;
			end
			OP_ADDI: begin
				alu_op = ALU_ADD;
				ov_check = 1'b1;
			end
			OP_ADDIU: alu_op = ALU_ADD;
			OP_SLTI: alu_op = ALU_SLT;
			// compare is unsigned but the immediate is still sign-extended
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				op_b = imm_zx;
				alu_op = (inst.i.opcode == OP_ANDI) ? ALU_AND :
					(inst.i.opcode == OP_ORI) ? ALU_OR :
					(inst.i.opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
			end
			default: dest = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= inst_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			d_alu_op <= alu_op;
			d_ov_check <= ov_check;
			d_syscall <= is_syscall;
			d_break <= is_break;
			d_a <= op_a;
			d_b <= op_b;
			d_shamt <= shamt;
			d_dest <= dest;
			d_exc_in_valid <= exc_in_valid;
			d_exc_in_code <= exc_in_code;
		end
	end

	a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(d_valid));

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

	localparam int WORD_W = 32;
	localparam int REG_W = 5;
	localparam int OP_W = 6;
	localparam int SHAMT_W = 5;
	localparam int IMM_W = 16;
	localparam logic [REG_W-1:0] LINK_REG = 5'd31;

	// primary opcodes
	localparam logic [OP_W-1:0] OP_SPECIAL = 6'b000000;
	localparam logic [OP_W-1:0] OP_SPECIAL2 = 6'b011100;
	localparam logic [OP_W-1:0] OP_JAL = 6'b000011;
	localparam logic [OP_W-1:0] OP_ADDI = 6'b001000;
	localparam logic [OP_W-1:0] OP_ADDIU = 6'b001001;
	localparam logic [OP_W-1:0] OP_SLTI = 6'b001010;
	localparam logic [OP_W-1:0] OP_SLTIU = 6'b001011;
	localparam logic [OP_W-1:0] OP_ANDI = 6'b001100;
	localparam logic [OP_W-1:0] OP_ORI = 6'b001101;
	localparam logic [OP_W-1:0] OP_XORI = 6'b001110;
	localparam logic [OP_W-1:0] OP_LUI = 6'b001111;

	// function codes under SPECIAL
	localparam logic [OP_W-1:0] FN_SLL = 6'b000000;
	localparam logic [OP_W-1:0] FN_SRL = 6'b000010;
	localparam logic [OP_W-1:0] FN_SRA = 6'b000011;
	localparam logic [OP_W-1:0] FN_SLLV = 6'b000100;
	localparam logic [OP_W-1:0] FN_SRLV = 6'b000110;
	localparam logic [OP_W-1:0] FN_SRAV = 6'b000111;
	localparam logic [OP_W-1:0] FN_SYSCALL = 6'b001100;
	localparam logic [OP_W-1:0] FN_BREAK = 6'b001101;
	localparam logic [OP_W-1:0] FN_ADD = 6'b100000;
	localparam logic [OP_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [OP_W-1:0] FN_SUB = 6'b100010;
	localparam logic [OP_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [OP_W-1:0] FN_AND = 6'b100100;
	localparam logic [OP_W-1:0] FN_OR = 6'b100101;
	localparam logic [OP_W-1:0] FN_XOR = 6'b100110;
	localparam logic [OP_W-1:0] FN_NOR = 6'b100111;
	localparam logic [OP_W-1:0] FN_SLT = 6'b101010;
	localparam logic [OP_W-1:0] FN_SLTU = 6'b101011;

	// function codes under SPECIAL2
	localparam logic [OP_W-1:0] FN_CLZ = 6'b100000;
	localparam logic [OP_W-1:0] FN_CLO = 6'b100001;

	// internal ALU operations
	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_NOR = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd10;
	localparam logic [ALU_OP_W-1:0] ALU_LUI = 4'd11;
	localparam logic [ALU_OP_W-1:0] ALU_CLZ = 4'd12;
	localparam logic [ALU_OP_W-1:0] ALU_CLO = 4'd13;
	localparam logic [ALU_OP_W-1:0] ALU_LINK = 4'd14;
	localparam logic [ALU_OP_W-1:0] ALU_ZERO = 4'd15;

	localparam int EXC_W = 6;
	localparam logic [EXC_W-1:0] EXC_OVERFLOW = 6'd12;
	localparam logic [EXC_W-1:0] EXC_SYSCALL = 6'd8;
	localparam logic [EXC_W-1:0] EXC_BREAK = 6'd9;

	// same instruction word, R-format and I-format views
	typedef union packed {
		struct packed {
			logic [OP_W-1:0] opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [REG_W-1:0] rd;
			logic [SHAMT_W-1:0] shamt;
			logic [OP_W-1:0] funct;
		} r;
		struct packed {
			logic [OP_W-1:0] opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [IMM_W-1:0] imm16;
		} i;
	} instr_t;

endpackage
